/* design/dma_consts.svh */
// ========================================
// widths, limits and FIFO depths of the
// DMA write engine.
// ========================================
`ifndef DMA_CONSTS_SVH
`define DMA_CONSTS_SVH

// address and data path.
`define DMA_ADDR_W 32
`define DMA_DATA_W 64

// descriptor length in beats, burst limits.
`define DMA_LENGTH_W 12
`define DMA_MAX_BURST 16
`define DMA_BURST_LEN_W 8

`define DMA_PERF_W 32

// queue depths.
`define DMA_DESC_DEPTH 4
`define DMA_DATA_DEPTH 32

`endif

/* design/dma_pkg.sv */
// ========================================
// descriptor, beat and response types, and
// the write FSM state encoding.
// ========================================
`include "dma_consts.svh"

package dma_pkg;

   typedef struct packed {
      logic [`DMA_ADDR_W-1:0]   dest_addr;
      logic [`DMA_LENGTH_W-1:0] length;
   } t_dma_descriptor;

   typedef logic [`DMA_DATA_W-1:0] t_dma_data;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } t_axi_resp;

   // ========================================
   // write FSM states, one-hot.
   // ========================================
   typedef enum int {
      IDLE_BIT,
      ADDR_SETUP_BIT,
      WRITE_DATA_BIT,
      WAIT_RSP_BIT,
      ERROR_BIT
   } t_wr_state_idx;

   typedef enum logic [4:0] {
      IDLE       = 5'b1 << IDLE_BIT,
      ADDR_SETUP = 5'b1 << ADDR_SETUP_BIT,
      WRITE_DATA = 5'b1 << WRITE_DATA_BIT,
      WAIT_RSP   = 5'b1 << WAIT_RSP_BIT,
      ERROR      = 5'b1 << ERROR_BIT
   } t_wr_state;

   // only incrementing bursts are issued.
   localparam logic [1:0] AXI_BURST_INCR = 2'b01;

endpackage

/* design/dma_fifo.sv */
// ========================================
// first-word-fall-through synchronous FIFO
// ========================================
module dma_fifo #(
   parameter type item_t = logic,
   parameter int  DEPTH  = 4
) (
   input  logic  clk,
   input  logic  reset_n,
   input  logic  push,
   input  item_t push_data,
   input  logic  pop,
   output item_t pop_data,
   output logic  not_empty,
   output logic  full
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   item_t            mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   // wrap at DEPTH, so any depth works.
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1))
         return '0;
      return ptr + 1'b1;
   endfunction

   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr] <= push_data;
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= ptr_inc(wr_ptr);
         if (pop)
            rd_ptr <= ptr_inc(rd_ptr);
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // head item is always visible.
   assign pop_data  = mem[rd_ptr];
   assign not_empty = (count != '0);
   assign full      = (count == CNT_W'(DEPTH));

   a_no_push_full: assert property (@(posedge clk) disable iff (!reset_n)
      push |-> !full);
   a_no_pop_empty: assert property (@(posedge clk) disable iff (!reset_n)
      pop |-> not_empty);

endmodule

/* design/dma_write_dest_fsm.sv */
// ========================================
// burst-splitting write FSM with status and
// performance counters.
// ========================================
`include "dma_consts.svh"

module dma_write_dest_fsm (
   input  logic                        clk,
   input  logic                        reset_n,
   input  logic                        desc_not_empty,
   input  dma_pkg::t_dma_descriptor    desc,
   output logic                        desc_pop,
   input  logic                        data_not_empty,
   input  dma_pkg::t_dma_data          data,
   output logic                        data_pop,
   output logic                        aw_valid,
   input  logic                        aw_ready,
   output logic [`DMA_ADDR_W-1:0]      aw_addr,
   output logic [`DMA_BURST_LEN_W-1:0] aw_len,
   output logic [2:0]                  aw_size,
   output logic [1:0]                  aw_burst,
   output logic                        w_valid,
   input  logic                        w_ready,
   output dma_pkg::t_dma_data          w_data,
   output logic                        w_last,
   input  logic                        b_valid,
   output logic                        b_ready,
   input  dma_pkg::t_axi_resp          b_resp,
   input  logic                        clear_error,
   output logic                        done,
   output logic                        busy,
   output logic                        error,
   output dma_pkg::t_wr_state          state,
   output logic [`DMA_PERF_W-1:0]      perf_clk_cnt,
   output logic [`DMA_PERF_W-1:0]      perf_beat_cnt
);
   import dma_pkg::*;

   localparam int BEAT_CNT_W = $clog2(`DMA_MAX_BURST + 1);
   localparam int BYTE_SHIFT = $clog2(`DMA_DATA_W / 8);

   t_wr_state                next_state;
   logic [`DMA_LENGTH_W-1:0] beats_remaining;
   logic [BEAT_CNT_W-1:0]    burst_beats_left;
   logic [BEAT_CNT_W-1:0]    first_beats;
   logic [BEAT_CNT_W-1:0]    next_beats;
   logic [`DMA_ADDR_W-1:0]   next_addr;
   logic                     start_desc;
   logic                     aw_fire;
   logic                     w_fire;
   logic                     b_fire;
   logic                     rsp_ok;
   logic                     rsp_err;
   logic                     last_beat;
   logic                     next_burst;
   logic                     desc_complete;

   // beats in one burst, capped at the burst limit.
   function automatic logic [BEAT_CNT_W-1:0] burst_beats(
      input logic [`DMA_LENGTH_W-1:0] beats
   );
      if (beats >= `DMA_MAX_BURST)
         return BEAT_CNT_W'(`DMA_MAX_BURST);
      return beats[BEAT_CNT_W-1:0];
   endfunction

   // ========================================
   // handshakes and burst arithmetic
   // ========================================
   assign aw_fire   = aw_valid & aw_ready;
   assign w_fire    = w_valid & w_ready;
   assign b_fire    = b_valid & b_ready;
   assign last_beat = w_fire & w_last;
   assign rsp_ok    = b_fire & ((b_resp == OKAY) | (b_resp == EXOKAY));
   assign rsp_err   = b_fire & ((b_resp == SLVERR) | (b_resp == DECERR));

   assign start_desc    = state[IDLE_BIT] & desc_not_empty;
   assign next_burst    = state[WAIT_RSP_BIT] & rsp_ok & (beats_remaining != '0);
   assign desc_complete = state[WAIT_RSP_BIT] & rsp_ok & (beats_remaining == '0);

   assign first_beats = burst_beats(desc.length);
   assign next_beats  = burst_beats(beats_remaining);
   // step past the burst just written.
   assign next_addr   = aw_addr + ((`DMA_ADDR_W'(aw_len) + 1'b1) << BYTE_SHIFT);

   // ========================================
   // state register and next state
   // ========================================
   always_ff @(posedge clk) begin
      if (!reset_n)
         state <= IDLE;
      else
         state <= next_state;
   end

   always_comb begin
      next_state = state;
      unique case (1'b1)
         state[IDLE_BIT]: begin
            if (desc_not_empty)
               next_state = ADDR_SETUP;
         end
         state[ADDR_SETUP_BIT]: begin
            if (aw_fire)
               next_state = WRITE_DATA;
         end
         state[WRITE_DATA_BIT]: begin
            if (last_beat)
               next_state = WAIT_RSP;
         end
         state[WAIT_RSP_BIT]: begin
            if (next_burst)
               next_state = ADDR_SETUP;
            else if (desc_complete)
               next_state = IDLE;
            else if (rsp_err)
               next_state = ERROR;
         end
         state[ERROR_BIT]: begin
            if (clear_error)
               next_state = IDLE;
         end
         default: next_state = IDLE;
      endcase
   end

   // beat bookkeeping and counters.
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         beats_remaining  <= '0;
         burst_beats_left <= '0;
         perf_clk_cnt     <= '0;
         perf_beat_cnt    <= '0;
      end else begin
         if (start_desc) begin
            beats_remaining  <= desc.length - `DMA_LENGTH_W'(first_beats);
            burst_beats_left <= first_beats;
            perf_clk_cnt     <= '0;
            perf_beat_cnt    <= '0;
         end else if (next_burst) begin
            beats_remaining  <= beats_remaining - `DMA_LENGTH_W'(next_beats);
            burst_beats_left <= next_beats;
         end
         if (state[WRITE_DATA_BIT]) begin
            perf_clk_cnt <= perf_clk_cnt + 1'b1;
            if (w_fire) begin
               perf_beat_cnt    <= perf_beat_cnt + 1'b1;
               burst_beats_left <= burst_beats_left - 1'b1;
            end
         end
      end
   end

   // burst fields, loaded one cycle ahead of aw_valid.
   always_ff @(posedge clk) begin
      if (start_desc) begin
         aw_addr <= desc.dest_addr;
         aw_len  <= `DMA_BURST_LEN_W'(first_beats) - 1'b1;
      end else if (next_burst) begin
         aw_addr <= next_addr;
         aw_len  <= `DMA_BURST_LEN_W'(next_beats) - 1'b1;
      end
   end

   // ========================================
   // outputs
   // ========================================
   assign aw_valid = state[ADDR_SETUP_BIT];
   assign aw_size  = 3'(BYTE_SHIFT);
   assign aw_burst = AXI_BURST_INCR;

   assign w_valid  = state[WRITE_DATA_BIT] & data_not_empty;
   assign w_data   = data;
   assign w_last   = state[WRITE_DATA_BIT] & (burst_beats_left == BEAT_CNT_W'(1));
   assign data_pop = w_fire;

   assign b_ready  = 1'b1;
   // pop on completion, or drop the failed descriptor.
   assign desc_pop = desc_complete | (state[ERROR_BIT] & clear_error);
   assign done     = desc_complete;
   assign busy     = ~state[IDLE_BIT];
   assign error    = state[ERROR_BIT];

   a_aw_stable: assert property (@(posedge clk) disable iff (!reset_n)
      aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr) && $stable(aw_len));
   a_w_hold: assert property (@(posedge clk) disable iff (!reset_n)
      w_valid && !w_ready |=> w_valid && $stable(w_data));
   a_state_onehot: assert property (@(posedge clk) disable iff (!reset_n)
      $onehot(state));

endmodule

/* design/dma_write_top.sv */
// ========================================
// DMA write engine top level.
// ========================================
`include "dma_consts.svh"

module dma_write_top (
   input  logic                        clk,
   input  logic                        reset_n,
   input  logic                        desc_push,
   input  logic [`DMA_ADDR_W-1:0]      desc_dest_addr,
   input  logic [`DMA_LENGTH_W-1:0]    desc_length,
   output logic                        desc_full,
   input  logic                        data_push,
   input  dma_pkg::t_dma_data          data_in,
   output logic                        data_full,
   output logic                        aw_valid,
   input  logic                        aw_ready,
   output logic [`DMA_ADDR_W-1:0]      aw_addr,
   output logic [`DMA_BURST_LEN_W-1:0] aw_len,
   output logic [2:0]                  aw_size,
   output logic [1:0]                  aw_burst,
   output logic                        w_valid,
   input  logic                        w_ready,
   output dma_pkg::t_dma_data          w_data,
   output logic                        w_last,
   input  logic                        b_valid,
   output logic                        b_ready,
   input  dma_pkg::t_axi_resp          b_resp,
   input  logic                        clear_error,
   output logic                        done,
   output logic                        busy,
   output logic                        error,
   output dma_pkg::t_wr_state          state,
   output logic [`DMA_PERF_W-1:0]      perf_clk_cnt,
   output logic [`DMA_PERF_W-1:0]      perf_beat_cnt
);
   import dma_pkg::*;

   t_dma_descriptor desc_in;
   t_dma_descriptor desc_head;
   logic            desc_not_empty;
   logic            desc_pop;
   t_dma_data       data_head;
   logic            data_not_empty;
   logic            data_pop;

   assign desc_in = '{dest_addr: desc_dest_addr, length: desc_length};

   // ========================================
   // descriptor and data queues
   // ========================================
   dma_fifo #(
      .item_t (t_dma_descriptor),
      .DEPTH  (`DMA_DESC_DEPTH)
   ) u_desc_fifo (
      .clk       (clk),
      .reset_n   (reset_n),
      .push      (desc_push),
      .push_data (desc_in),
      .pop       (desc_pop),
      .pop_data  (desc_head),
      .not_empty (desc_not_empty),
      .full      (desc_full)
   );

   dma_fifo #(
      .item_t (t_dma_data),
      .DEPTH  (`DMA_DATA_DEPTH)
   ) u_data_fifo (
      .clk       (clk),
      .reset_n   (reset_n),
      .push      (data_push),
      .push_data (data_in),
      .pop       (data_pop),
      .pop_data  (data_head),
      .not_empty (data_not_empty),
      .full      (data_full)
   );

   dma_write_dest_fsm u_wr_fsm (
      .clk            (clk),
      .reset_n        (reset_n),
      .desc_not_empty (desc_not_empty),
      .desc           (desc_head),
      .desc_pop       (desc_pop),
      .data_not_empty (data_not_empty),
      .data           (data_head),
      .data_pop       (data_pop),
      .aw_valid       (aw_valid),
      .aw_ready       (aw_ready),
      .aw_addr        (aw_addr),
      .aw_len         (aw_len),
      .aw_size        (aw_size),
      .aw_burst       (aw_burst),
      .w_valid        (w_valid),
      .w_ready        (w_ready),
      .w_data         (w_data),
      .w_last         (w_last),
      .b_valid        (b_valid),
      .b_ready        (b_ready),
      .b_resp         (b_resp),
      .clear_error    (clear_error),
      .done           (done),
      .busy           (busy),
      .error          (error),
      .state          (state),
      .perf_clk_cnt   (perf_clk_cnt),
      .perf_beat_cnt  (perf_beat_cnt)
   );

endmodule

/* bench/tb_clock_gen.sv */
// ========================================
// testbench clock and reset.
// ========================================
module tb_clock_gen (
   output logic clk,
   output logic reset_n
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // reset held over three rising edges.
   initial begin
      reset_n = 1'b0;
      repeat (3) @(posedge clk);
      #1 reset_n = 1'b1;
   end

endmodule

/* bench/axi_wr_sink_model.sv */
// ========================================
// AXI write slave with random stalls that
// records bursts and beats.
// ========================================
`include "dma_consts.svh"

module axi_wr_sink_model (
   input  logic                        clk,
   input  logic                        reset_n,
   input  logic                        aw_valid,
   output logic                        aw_ready,
   input  logic [`DMA_ADDR_W-1:0]      aw_addr,
   input  logic [`DMA_BURST_LEN_W-1:0] aw_len,
   input  logic [2:0]                  aw_size,
   input  logic [1:0]                  aw_burst,
   input  logic                        w_valid,
   output logic                        w_ready,
   input  logic [`DMA_DATA_W-1:0]      w_data,
   input  logic                        w_last,
   output logic                        b_valid,
   input  logic                        b_ready,
   output dma_pkg::t_axi_resp          b_resp,
   input  logic                        err_resp
);
   timeunit 1ns;
   timeprecision 100ps;
   import dma_pkg::*;

   // accepted address phases and beats, in order.
   logic [`DMA_ADDR_W-1:0]      rec_addr_q[$];
   logic [`DMA_BURST_LEN_W-1:0] rec_len_q[$];
   logic [2:0]                  rec_size_q[$];
   logic [1:0]                  rec_burst_q[$];
   logic [`DMA_DATA_W-1:0]      rec_data_q[$];
   logic                        rec_last_q[$];
   int                          rsp_pending = 0;
   logic                        b_taken;

   initial begin
      aw_ready = 1'b0;
      w_ready  = 1'b0;
      b_valid  = 1'b0;
      b_resp   = OKAY;
   end

   always begin
      @(negedge clk);
      if (aw_valid && aw_ready) begin
         rec_addr_q.push_back(aw_addr);
         rec_len_q.push_back(aw_len);
         rec_size_q.push_back(aw_size);
         rec_burst_q.push_back(aw_burst);
      end
      if (w_valid && w_ready) begin
         rec_data_q.push_back(w_data);
         rec_last_q.push_back(w_last);
         if (w_last)
            rsp_pending++;
      end
      b_taken = b_valid && b_ready;
      @(posedge clk);
      #1;
      // not ready while reset is held.
      aw_ready = reset_n && ($urandom % 4) != 0;
      w_ready  = reset_n && ($urandom % 4) != 0;
      if (b_taken) begin
         b_valid = 1'b0;
         rsp_pending--;
      end
      // one response at a time, after a random delay.
      if (!b_valid && rsp_pending > 0 && ($urandom % 2) == 0) begin
         b_valid = 1'b1;
         b_resp  = err_resp ? SLVERR : OKAY;
      end
   end

endmodule

/* bench/tb_dma_write.sv */
// ========================================
// DMA write engine testbench with random
// descriptors, a reference model and checks.
// ========================================
`include "dma_consts.svh"

module tb_dma_write;
   timeunit 1ns;
   timeprecision 100ps;
   import dma_pkg::*;

   localparam int TIMEOUT   = 5000;
   localparam int NUM_DESC  = 12;
   localparam int ERR_IDX   = 5;
   localparam int SIZE_CODE = 3;
   // AXI encoding of an incrementing burst.
   localparam logic [1:0] BURST_INCR = 2'b01;

   logic                        clk;
   logic                        reset_n;
   logic                        desc_push;
   logic [`DMA_ADDR_W-1:0]      desc_dest_addr;
   logic [`DMA_LENGTH_W-1:0]    desc_length;
   logic                        data_push;
   logic [`DMA_DATA_W-1:0]      data_in;
   logic                        desc_full, data_full;
   logic                        aw_valid, aw_ready;
   logic [`DMA_ADDR_W-1:0]      aw_addr;
   logic [`DMA_BURST_LEN_W-1:0] aw_len;
   logic [2:0]                  aw_size;
   logic [1:0]                  aw_burst;
   logic                        w_valid, w_ready, w_last;
   logic [`DMA_DATA_W-1:0]      w_data;
   logic                        b_valid, b_ready;
   t_axi_resp                   b_resp;
   logic                        clear_error, err_resp;
   logic                        done, busy, error;
   t_wr_state                   state;
   logic [`DMA_PERF_W-1:0]      perf_clk_cnt, perf_beat_cnt;

   // reference model.
   logic [`DMA_ADDR_W-1:0]      exp_addr_q[$];
   logic [`DMA_BURST_LEN_W-1:0] exp_len_q[$];
   logic [`DMA_DATA_W-1:0]      exp_data_q[$];
   logic                        exp_last_q[$];
   int                          exp_done_q[$];
   int                          error_cnt = 0;
   int                          done_cnt = 0;

   tb_clock_gen u_clock_gen (.*);
   dma_write_top u_dma_write_top (.*);
   axi_wr_sink_model u_sink (.*);

   task automatic report_mismatch(input string msg);
      $display("MISMATCH at %0t: %s", $time, msg);
      error_cnt++;
   endtask

   task automatic abort_timeout(input string what);
      $display("timeout waiting for %s at %0t", what, $time);
      $display("%0d errors before the timeout", error_cnt);
      $display("Test failed");
      $finish;
   endtask

   function automatic logic condition_holds(input string what, input int n);
      if (what == "reset release")
         return reset_n;
      if (what == "done")
         return done_cnt >= n;
      if (what == "error")
         return error;
      return !desc_full;
   endfunction

   task automatic wait_until(input string what, input int n);
      int cycles = 0;
      @(negedge clk);
      while (!condition_holds(what, n)) begin
         cycles++;
         if (cycles >= TIMEOUT)
            abort_timeout(what);
         @(negedge clk);
      end
   endtask

   // split a descriptor into bursts, return the beats it expects.
   function automatic int expect_bursts(input logic [`DMA_ADDR_W-1:0] addr, input int len,
                                        input bit first_only);
      int beats;
      int total = 0;
      while (len > 0) begin
         beats = (len > `DMA_MAX_BURST) ? `DMA_MAX_BURST : len;
         exp_addr_q.push_back(addr);
         exp_len_q.push_back(`DMA_BURST_LEN_W'(beats - 1));
         for (int b = 0; b < beats; b++)
            exp_last_q.push_back(b == beats - 1);
         addr  = addr + `DMA_ADDR_W'(beats * 8);
         total = total + beats;
         len   = first_only ? 0 : len - beats;
      end
      return total;
   endfunction

   task automatic push_desc(input logic [`DMA_ADDR_W-1:0] addr, input int len);
      wait_until("descriptor queue space", 0);
      @(posedge clk);
      #1;
      desc_push      = 1'b1;
      desc_dest_addr = addr;
      desc_length    = `DMA_LENGTH_W'(len);
      @(posedge clk);
      #1;
      desc_push = 1'b0;
   endtask

   task automatic push_beats(input int count);
      int cycles = 0;
      int sent = 0;
      while (sent < count) begin
         @(posedge clk);
         #1;
         data_push = !data_full;
         if (data_push) begin
            data_in = {$urandom, $urandom};
            exp_data_q.push_back(data_in);
            sent++;
            cycles = 0;
         end else begin
            cycles++;
            if (cycles >= TIMEOUT)
               abort_timeout("data queue space");
         end
      end
      @(posedge clk);
      #1;
      data_push = 1'b0;
   endtask

   task automatic check_error_park(input int idx);
      wait_until("error", 0);
      err_resp = 1'b0;
      for (int c = 0; c < 20; c++) begin
         if (aw_valid)
            report_mismatch("address phase issued while parked in error");
         if (state != ERROR || !error)
            report_mismatch($sformatf("state %b while parked, expected ERROR", state));
         @(negedge clk);
      end
      @(posedge clk);
      #1 clear_error = 1'b1;
      @(posedge clk);
      #1 clear_error = 1'b0;
      @(negedge clk);
      if (error)
         report_mismatch("error still high after clear_error");
      if (done_cnt != idx)
         report_mismatch($sformatf("%0d done pulses, expected %0d", done_cnt, idx));
   endtask

   task automatic compare_records();
      if (u_sink.rec_addr_q.size() != exp_addr_q.size())
         report_mismatch($sformatf("%0d bursts seen, expected %0d",
                                   u_sink.rec_addr_q.size(), exp_addr_q.size()));
      for (int k = 0; k < exp_addr_q.size() && k < u_sink.rec_addr_q.size(); k++) begin
         if (u_sink.rec_addr_q[k] != exp_addr_q[k] || u_sink.rec_len_q[k] != exp_len_q[k] ||
             u_sink.rec_size_q[k] != SIZE_CODE || u_sink.rec_burst_q[k] != BURST_INCR)
            report_mismatch($sformatf("burst %0d addr %h len %0d, expected addr %h len %0d",
                                      k, u_sink.rec_addr_q[k], u_sink.rec_len_q[k],
                                      exp_addr_q[k], exp_len_q[k]));
      end
      if (u_sink.rec_data_q.size() != exp_data_q.size())
         report_mismatch($sformatf("%0d beats seen, expected %0d",
                                   u_sink.rec_data_q.size(), exp_data_q.size()));
      for (int k = 0; k < exp_data_q.size() && k < u_sink.rec_data_q.size(); k++) begin
         if (u_sink.rec_data_q[k] != exp_data_q[k] || u_sink.rec_last_q[k] != exp_last_q[k])
            report_mismatch($sformatf("beat %0d data %h last %b, expected %h last %b", k,
                                      u_sink.rec_data_q[k], u_sink.rec_last_q[k],
                                      exp_data_q[k], exp_last_q[k]));
      end
   endtask

   // counters are checked on the cycle of each done pulse.
   always @(negedge clk) begin : done_monitor
      int exp_len;
      if (reset_n && done) begin
         done_cnt++;
         if (exp_done_q.size() == 0) begin
            report_mismatch("done pulse with no descriptor expected");
         end else begin
            exp_len = exp_done_q.pop_front();
            if (perf_beat_cnt != exp_len)
               report_mismatch($sformatf("perf_beat_cnt %0d, expected %0d",
                                         perf_beat_cnt, exp_len));
            if (perf_clk_cnt < exp_len)
               report_mismatch($sformatf("perf_clk_cnt %0d below length %0d",
                                         perf_clk_cnt, exp_len));
         end
      end
   end

   initial begin : stimulus
      int len;
      int beats;
      logic [`DMA_ADDR_W-1:0] addr;
      void'($urandom(2));
      desc_push      = 1'b0;
      desc_dest_addr = '0;
      desc_length    = '0;
      data_push      = 1'b0;
      data_in        = '0;
      clear_error    = 1'b0;
      err_resp       = 1'b0;
      wait_until("reset release", 0);
      if (aw_valid || w_valid || done || busy || error || state != IDLE)
         report_mismatch("outputs not idle after reset");
      if (!b_ready)
         report_mismatch("b_ready low, expected it held high");
      for (int i = 0; i < NUM_DESC; i++) begin
         addr  = $urandom & ~`DMA_ADDR_W'(7);
         len   = (i == ERR_IDX) ? 17 + $urandom_range(23) : 1 + $urandom_range(39);
         beats = expect_bursts(addr, len, i == ERR_IDX);
         if (i != ERR_IDX)
            exp_done_q.push_back(len);
         push_desc(addr, len);
         if (i == ERR_IDX) begin
            // earlier descriptors finish before the error response is armed.
            wait_until("done", i);
            err_resp = 1'b1;
            push_beats(beats);
            check_error_park(i);
         end else begin
            push_beats(beats);
         end
      end
      wait_until("done", NUM_DESC - 1);
      @(negedge clk);
      if (busy || state != IDLE)
         report_mismatch($sformatf("busy %b state %b after the last done", busy, state));
      compare_records();
      $display("%0d errors, %0d done pulses", error_cnt, done_cnt);
      if (error_cnt == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

/* vlog.f */
+incdir+design
design/dma_pkg.sv
design/dma_fifo.sv
design/dma_write_dest_fsm.sv
design/dma_write_top.sv
bench/tb_clock_gen.sv
bench/axi_wr_sink_model.sv
bench/tb_dma_write.sv

/* run_sim.sh */
#!/bin/sh
# build the DMA write testbench with Verilator, run it, then scan the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
   --top-module tb_dma_write -f vlog.f -Mdir obj_dir -o tb_dma_write > build.log 2>&1 \
   || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_dma_write > sim.log 2>&1
cat sim.log
grep -q "Test failed" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "no result in sim.log"; exit 1; }
echo "simulation passed"
